// ==== filelist.f ====
rtl/rvIsaPkg.sv
rtl/coreCtrlPkg.sv
rtl/immGen.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/coreControl.sv
rtl/rvCore.sv
dv/rvCore_asserts.sv
dv/coreChecker.sv
dv/tbCore.sv

// ==== Makefile ====
SRCS := $(shell cat filelist.f)

.PHONY: run clean

obj_dir/VtbCore: filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module tbCore -f filelist.f

run: obj_dir/VtbCore
	@out="$$(./obj_dir/VtbCore)"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== dv/tbCore.sv ====
module tbCore;

    localparam int progLen       = 64;
    localparam int resetCycles   = 16;
    localparam int timeoutCycles = progLen * 4 * 3 + resetCycles;

    logic               clk       = 1'b0;
    logic               arstN     = 1'b0;
    rvIsaPkg::instrWord instr     = '0;
    rvIsaPkg::word      dataRdata = '0;
    rvIsaPkg::word      instrAddr, dataAddr, dataWdata, retired;
    logic               dataWe;
    int                 valErrors, seqErrors;

    rvIsaPkg::instrWord imem [progLen];
    rvIsaPkg::word      dmem [256];
    logic [31:0]        lfsr = 32'hde39;

    rvCore u_dut (.clk, .arstN, .instrAddr, .instr, .dataAddr, .dataWdata, .dataWe,
                  .dataRdata, .retired);

    coreChecker chk (.clk, .arstN, .instrAddr, .instr, .dataAddr, .dataWdata, .dataWe,
                     .retired, .valErrors, .seqErrors);

    bind rvCore rvCore_asserts u_asserts (.clk, .arstN, .curStage, .latchedInstr, .dataWe,
                                          .retired);

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0); // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
        return v;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] rs2,
                                         input logic [2:0] rs1, input logic [2:0] f3,
                                         input logic [2:0] rd);
        return {f7, 2'b00, rs2, 2'b00, rs1, f3, 2'b00, rd, rvIsaPkg::opReg};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [2:0] rs1,
                                         input logic [2:0] f3, input logic [2:0] rd,
                                         input logic [6:0] op);
        return {imm, 2'b00, rs1, f3, 2'b00, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [2:0] rs2);
        return {imm[11:5], 2'b00, rs2, 5'd7, rvIsaPkg::f3Word, imm[4:0], rvIsaPkg::opStore};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [2:0] rs2,
                                         input logic [2:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], 2'b00, rs2, 2'b00, rs1, f3, imm[4:1], imm[11],
                rvIsaPkg::opBranch};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [2:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 2'b00, rd, rvIsaPkg::opJal};
    endfunction

    task automatic buildProgram();
        logic [2:0]  kind, rd, rs1, rs2, f3;
        logic [11:0] imm;
        logic        alt;
        int          k;
        imem[0] = encI(12'h400, 3'd0, rvIsaPkg::f3Add, 3'd7, rvIsaPkg::opImm); // Data base
        for (int i = 1; i < 7; i++) begin
            imem[i] = encI(12'(takeBits(12)), 3'd0, rvIsaPkg::f3Add, 3'(i), rvIsaPkg::opImm);
        end
        for (int i = 7; i < progLen; i++) begin
            kind = 3'(takeBits(3));
            rd   = 3'(takeBits(3));
            rs1  = 3'(takeBits(3));
            rs2  = 3'(takeBits(3));
            f3   = 3'(takeBits(3));
            alt  = (takeBits(1) != 0);
            k    = int'(takeBits(2)) + 1;
            if (rd == 3'd7) begin
                rd = 3'd0; // x7 keeps the base, so these go to x0
            end
            if (i + k > progLen) begin
                k = progLen - i;
            end
            case (kind)
                3'd0, 3'd1: begin
                    alt     = alt && (f3 == rvIsaPkg::f3Add || f3 == rvIsaPkg::f3Srl);
                    imem[i] = encR(alt ? rvIsaPkg::f7Alt : 7'd0, rs2, rs1, f3, rd);
                end
                3'd2: begin
                    imm = 12'(takeBits(12));
                    if (f3 == rvIsaPkg::f3Sll || f3 == rvIsaPkg::f3Srl) begin
                        imm = {(alt && f3 == rvIsaPkg::f3Srl) ? rvIsaPkg::f7Alt : 7'd0, imm[4:0]};
                    end
                    imem[i] = encI(imm, rs1, f3, rd, rvIsaPkg::opImm);
                end
                3'd3: imem[i] = encI({2'b00, 8'(takeBits(8)), 2'b00}, 3'd7, rvIsaPkg::f3Word,
                                     rd, rvIsaPkg::opLoad);
                3'd4: imem[i] = encS({2'b00, 8'(takeBits(8)), 2'b00}, rs2);
                3'd5: imem[i] = encB(13'(k * 4), rs2, rs1, {f3[2], f3[2] & f3[1], f3[0]});
                3'd6: imem[i] = encJ(21'(k * 4), rd);
                default: imem[i] = encI(12'(4 * (i + k)) | 12'(takeBits(1)), 3'd0,
                                        rvIsaPkg::f3Jalr, rd, rvIsaPkg::opJalr); // Odd target too
            endcase
        end
    endtask

    always begin
        @(posedge clk);
        #2;
        instr     = (instrAddr < 32'(progLen * 4)) ? imem[instrAddr[7:2]] : 32'h00000013;
        dataRdata = dmem[dataAddr[9:2]];
    end

    always @(negedge clk) begin
        if (!arstN) begin
            for (int j = 0; j < 256; j++) begin
                dmem[j] = chk.modelMem[j]; // Same start image as the model
            end
        end else if (dataWe) begin
            dmem[dataAddr[9:2]] = dataWdata;
        end
    end

    initial begin
        buildProgram();
        repeat (resetCycles) @(posedge clk);
        #2;
        arstN = 1'b1;
        while (instrAddr < 32'(progLen * 4)) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        $display("Summary: %0d value mismatches, %0d other errors", valErrors, seqErrors);
        if (valErrors + seqErrors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(timeoutCycles * 20);
        $display("Timeout: program did not reach its end within %0d cycles", timeoutCycles);
        $display("Summary: %0d value mismatches, %0d other errors", valErrors, seqErrors);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== dv/coreChecker.sv ====
module coreChecker (
    input  logic               clk,
    input  logic               arstN,
    input  rvIsaPkg::word      instrAddr,
    input  rvIsaPkg::instrWord instr,
    input  rvIsaPkg::word      dataAddr,
    input  rvIsaPkg::word      dataWdata,
    input  logic               dataWe,
    input  rvIsaPkg::word      retired,
    output int                 valErrors,
    output int                 seqErrors
);

    rvIsaPkg::word modelMem [256];
    rvIsaPkg::word xReg [32];
    rvIsaPkg::word pc, lastRetired, expAddr, expData;
    logic          running, expStore;
    int            cyc, weCycles;
    int            valCount = 0;
    int            seqCount = 0;

    assign valErrors = valCount;
    assign seqErrors = seqCount;

    task automatic compareValue(input string name, input rvIsaPkg::word exp,
                                input rvIsaPkg::word act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, got %h at %0t", name, exp, act, $time);
            valCount++;
        end
    endtask

    task automatic reportProblem(input string msg);
        $display("Error at %0t: %s", $time, msg);
        seqCount++;
    endtask

    // One instruction of the ISA model, from its own register and memory state
    task automatic execute(input rvIsaPkg::instrWord ins);
        rvIsaPkg::word a, b, r, addr, nxt, immI, immS, immB, immJ;
        logic          cond, wr;
        a        = xReg[ins[19:15]];
        b        = xReg[ins[24:20]];
        immI     = {{20{ins[31]}}, ins[31:20]};
        immS     = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB     = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immJ     = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt      = pc + 32'd4;
        r        = '0;
        wr       = 1'b0;
        cond     = 1'b0;
        expStore = 1'b0;
        case (ins[6:0])
            rvIsaPkg::opReg, rvIsaPkg::opImm: begin
                if (ins[6:0] == rvIsaPkg::opImm) begin
                    b = immI;
                end
                wr = 1'b1;
                case (ins[14:12])
                    rvIsaPkg::f3Add: begin
                        if (ins[6:0] == rvIsaPkg::opReg && ins[30]) begin
                            r = a - b;
                        end else begin
                            r = a + b;
                        end
                    end
                    rvIsaPkg::f3Sll:  r = a << b[4:0];
                    rvIsaPkg::f3Slt:  r = {31'd0, $signed(a) < $signed(b)};
                    rvIsaPkg::f3Sltu: r = {31'd0, a < b};
                    rvIsaPkg::f3Xor:  r = a ^ b;
                    rvIsaPkg::f3Srl: begin
                        if (ins[30]) begin
                            r = $signed(a) >>> b[4:0];
                        end else begin
                            r = a >> b[4:0];
                        end
                    end
                    rvIsaPkg::f3Or:   r = a | b;
                    default:          r = a & b;
                endcase
            end
            rvIsaPkg::opLoad: begin
                addr = a + immI;
                r    = modelMem[addr[9:2]];
                wr   = 1'b1;
            end
            rvIsaPkg::opStore: begin
                addr               = a + immS;
                expStore           = 1'b1;
                expAddr            = addr;
                expData            = b;
                modelMem[addr[9:2]] = b;
            end
            rvIsaPkg::opBranch: begin
                case (ins[14:12])
                    rvIsaPkg::f3Beq:  cond = (a == b);
                    rvIsaPkg::f3Bne:  cond = (a != b);
                    rvIsaPkg::f3Blt:  cond = ($signed(a) < $signed(b));
                    rvIsaPkg::f3Bge:  cond = ($signed(a) >= $signed(b));
                    rvIsaPkg::f3Bltu: cond = (a < b);
                    rvIsaPkg::f3Bgeu: cond = (a >= b);
                    default:          cond = 1'b0;
                endcase
                if (cond) begin
                    nxt = pc + immB;
                end
            end
            rvIsaPkg::opJal: begin
                r   = pc + 32'd4;
                wr  = 1'b1;
                nxt = pc + immJ;
            end
            rvIsaPkg::opJalr: begin
                r   = pc + 32'd4;
                wr  = 1'b1;
                nxt = (a + immI) & ~32'd1; // Target taken before the link write
            end
            default: ;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            xReg[ins[11:7]] = r;
        end
        pc = nxt;
    endtask

    always @(negedge clk) begin
        if (!arstN) begin
            compareValue("instrAddr", '0, instrAddr);
            compareValue("dataWe", '0, {31'd0, dataWe});
            compareValue("retired", '0, retired);
            for (int j = 0; j < 32; j++) begin
                xReg[j] = '0;
            end
            for (int j = 0; j < 256; j++) begin
                modelMem[j] = {8'hd5, 8'(j), ~8'(j), 8'(j * 37)};
            end
            pc          = '0;
            lastRetired = '0;
            running     = 1'b0;
            expStore    = 1'b0;
            cyc         = 0;
            weCycles    = 0;
        end else begin
            cyc++;
            if (dataWe) begin
                weCycles++;
                if (!expStore) begin
                    reportProblem("store strobe for an instruction that is not a store");
                end else begin
                    compareValue("dataAddr", expAddr, dataAddr);
                    compareValue("dataWdata", expData, dataWdata);
                end
            end
            if (running && cyc == 5) begin
                reportProblem("no retirement within four cycles");
            end
            if (!running || retired != lastRetired) begin
                if (running) begin
                    compareValue("retired", lastRetired + 32'd1, retired);
                    if (cyc != 4) begin
                        reportProblem("instruction did not take four cycles");
                    end
                    if (weCycles != (expStore ? 1 : 0)) begin
                        reportProblem("store strobe not high for exactly one cycle");
                    end
                end
                compareValue("instrAddr", pc, instrAddr);
                execute(instr);
                lastRetired = retired;
                running     = 1'b1;
                cyc         = 0;
                weCycles    = 0;
            end
        end
    end

endmodule

// ==== dv/rvCore_asserts.sv ====
module rvCore_asserts (
    input logic               clk,
    input logic               arstN,
    input coreCtrlPkg::stage  curStage,
    input rvIsaPkg::instrWord latchedInstr,
    input logic               dataWe,
    input rvIsaPkg::word      retired
);

    // Fetch, decode, execute, writeback, then wrap to fetch
    stageOrder: assert property (@(posedge clk) disable iff (!arstN)
        $past(arstN) |-> 2'(curStage) == 2'($past(curStage) + 2'd1))
        else $error("Stage did not follow the fixed order");

    // Only a decoded SW may strobe the data port
    storeInWriteback: assert property (@(posedge clk) disable iff (!arstN)
        dataWe |-> curStage == coreCtrlPkg::stWriteback
            && latchedInstr[6:0] == rvIsaPkg::opStore
            && latchedInstr[14:12] == rvIsaPkg::f3Word)
        else $error("Data write enable outside the writeback of a store");

    retiredMonotonic: assert property (@(posedge clk) disable iff (!arstN)
        retired >= $past(retired))
        else $error("Retired count went down");

endmodule

// ==== rtl/rvCore.sv ====
module rvCore (
    input  logic               clk,
    input  logic               arstN,
    output rvIsaPkg::word      instrAddr,
    input  rvIsaPkg::instrWord instr,
    output rvIsaPkg::word      dataAddr,
    output rvIsaPkg::word      dataWdata,
    output logic               dataWe,
    input  rvIsaPkg::word      dataRdata,
    output rvIsaPkg::word      retired
);

    coreCtrlPkg::stage      curStage;
    coreCtrlPkg::ctrlBundle ctrl;
    rvIsaPkg::instrWord     latchedInstr;
    rvIsaPkg::word pc, nextPc, pcPlus4, jumpTarget, jalrSum;
    rvIsaPkg::word imm, rs1Data, rs2Data, rs1Val, rs2Val;
    rvIsaPkg::word aluA, aluB, result, resultReg, storeData, wrData;
    logic taken, takenReg, regWe;

    coreControl u_ctrl (.clk, .arstN, .instr, .curStage, .latchedInstr, .ctrl, .retired);

    immGen u_imm (.latchedInstr, .immKind(ctrl.immKind), .imm);

    regFile u_regs (
        .clk, .arstN,
        .rs1(latchedInstr[19:15]), .rs2(latchedInstr[24:20]),
        .rs1Data, .rs2Data,
        .rd(latchedInstr[11:7]), .wrEn(regWe), .wrData
    );

    aluUnit u_alu (.op(ctrl.aluOp), .a(aluA), .b(aluB), .result, .taken);

    assign aluA = (ctrl.srcA == coreCtrlPkg::srcPc) ? pc : rs1Val;

    always_comb begin
        case (ctrl.srcB)
            coreCtrlPkg::srcImm:  aluB = imm;
            coreCtrlPkg::srcFour: aluB = 32'd4;
            default:              aluB = rs2Val;
        endcase
    end

    always_ff @(posedge clk) begin
        if (curStage == coreCtrlPkg::stDecode) begin
            rs1Val <= rs1Data;
            rs2Val <= rs2Data;
        end
        if (curStage == coreCtrlPkg::stExecute) begin
            resultReg <= result;
            storeData <= rs2Val;
        end
    end

    // Memory and register writes all land in writeback
    assign instrAddr = pc;
    assign dataAddr  = (ctrl.memRead || ctrl.memWrite) ? resultReg : '0;
    assign dataWdata = storeData;
    assign dataWe    = (curStage == coreCtrlPkg::stWriteback) && ctrl.memWrite;
    assign regWe     = (curStage == coreCtrlPkg::stWriteback) && ctrl.regWrite;
    assign wrData    = ctrl.wbFromMem ? dataRdata : resultReg; // Jumps carry the link in resultReg

    assign pcPlus4    = pc + 32'd4;
    assign jumpTarget = pc + imm; // Branch and JAL
    assign jalrSum    = rs1Val + imm;

    always_comb begin
        case (ctrl.pcSel)
            coreCtrlPkg::pcBranch: nextPc = (ctrl.isBranch && takenReg) ? jumpTarget : pcPlus4;
            coreCtrlPkg::pcJal:    nextPc = jumpTarget;
            coreCtrlPkg::pcJalr:   nextPc = {jalrSum[31:1], 1'b0};
            default:               nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc       <= '0;
            takenReg <= 1'b0;
        end else begin
            if (curStage == coreCtrlPkg::stExecute) begin
                takenReg <= taken;
            end
            if (curStage == coreCtrlPkg::stWriteback) begin
                pc <= nextPc;
            end
        end
    end

endmodule

// ==== rtl/coreControl.sv ====
module coreControl (
    input  logic                   clk,
    input  logic                   arstN,
    input  rvIsaPkg::instrWord     instr,
    output coreCtrlPkg::stage      curStage,
    output rvIsaPkg::instrWord     latchedInstr,
    output coreCtrlPkg::ctrlBundle ctrl,
    output rvIsaPkg::word          retired
);

    coreCtrlPkg::stage nextStage;
    rvIsaPkg::opcode   op;
    rvIsaPkg::funct3   f3;
    logic              alt;

    assign op  = latchedInstr[6:0];
    assign f3  = latchedInstr[14:12];
    assign alt = (latchedInstr[31:25] == rvIsaPkg::f7Alt);

    // Register and immediate forms share one funct3 map
    function automatic coreCtrlPkg::aluOp arithOp(
        input rvIsaPkg::funct3 fn,
        input logic            altBit,
        input logic            isImm
    );
        case (fn)
            rvIsaPkg::f3Add:  return (altBit && !isImm) ? coreCtrlPkg::aluSub : coreCtrlPkg::aluAdd;
            rvIsaPkg::f3Sll:  return coreCtrlPkg::aluSll;
            rvIsaPkg::f3Slt:  return coreCtrlPkg::aluSlt;
            rvIsaPkg::f3Sltu: return coreCtrlPkg::aluSltu;
            rvIsaPkg::f3Xor:  return coreCtrlPkg::aluXor;
            rvIsaPkg::f3Srl:  return altBit ? coreCtrlPkg::aluSra : coreCtrlPkg::aluSrl;
            rvIsaPkg::f3Or:   return coreCtrlPkg::aluOr;
            default:          return coreCtrlPkg::aluAnd;
        endcase
    endfunction

    always_comb begin
        case (curStage)
            coreCtrlPkg::stFetch:   nextStage = coreCtrlPkg::stDecode;
            coreCtrlPkg::stDecode:  nextStage = coreCtrlPkg::stExecute;
            coreCtrlPkg::stExecute: nextStage = coreCtrlPkg::stWriteback;
            default:                nextStage = coreCtrlPkg::stFetch;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            curStage     <= coreCtrlPkg::stFetch;
            latchedInstr <= '0; // Opcode 0 decodes as a no-op
            retired      <= '0;
        end else begin
            curStage <= nextStage;
            if (curStage == coreCtrlPkg::stFetch) begin
                latchedInstr <= instr;
            end
            if (curStage == coreCtrlPkg::stWriteback) begin
                retired <= retired + 32'd1;
            end
        end
    end

    always_comb begin
        ctrl.srcA      = coreCtrlPkg::srcRs1;
        ctrl.srcB      = coreCtrlPkg::srcRs2;
        ctrl.aluOp     = coreCtrlPkg::aluAdd;
        ctrl.immKind   = coreCtrlPkg::immI;
        ctrl.regWrite  = 1'b0;
        ctrl.memRead   = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.isBranch  = 1'b0;
        ctrl.pcSel     = coreCtrlPkg::pcPlus4;
        ctrl.wbFromMem = 1'b0;
        case (op)
            rvIsaPkg::opReg: begin
                ctrl.aluOp    = arithOp(f3, alt, 1'b0);
                ctrl.regWrite = 1'b1;
            end
            rvIsaPkg::opImm: begin
                ctrl.srcB     = coreCtrlPkg::srcImm;
                ctrl.aluOp    = arithOp(f3, alt, 1'b1);
                ctrl.regWrite = 1'b1;
            end
            rvIsaPkg::opLoad: if (f3 == rvIsaPkg::f3Word) begin
                ctrl.srcB      = coreCtrlPkg::srcImm;
                ctrl.memRead   = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.wbFromMem = 1'b1;
            end
            rvIsaPkg::opStore: if (f3 == rvIsaPkg::f3Word) begin
                ctrl.srcB     = coreCtrlPkg::srcImm;
                ctrl.immKind  = coreCtrlPkg::immS;
                ctrl.memWrite = 1'b1;
            end
            rvIsaPkg::opBranch: begin
                ctrl.immKind  = coreCtrlPkg::immB;
                ctrl.pcSel    = coreCtrlPkg::pcBranch;
                ctrl.isBranch = 1'b1;
                case (f3)
                    rvIsaPkg::f3Beq:  ctrl.aluOp = coreCtrlPkg::aluEq;
                    rvIsaPkg::f3Bne:  ctrl.aluOp = coreCtrlPkg::aluNe;
                    rvIsaPkg::f3Blt:  ctrl.aluOp = coreCtrlPkg::aluLt;
                    rvIsaPkg::f3Bge:  ctrl.aluOp = coreCtrlPkg::aluGe;
                    rvIsaPkg::f3Bltu: ctrl.aluOp = coreCtrlPkg::aluLtu;
                    rvIsaPkg::f3Bgeu: ctrl.aluOp = coreCtrlPkg::aluGeu;
                    default:          ctrl.isBranch = 1'b0; // Reserved, falls through
                endcase
            end
            rvIsaPkg::opJal: begin
                ctrl.srcA     = coreCtrlPkg::srcPc; // ALU forms the link PC+4
                ctrl.srcB     = coreCtrlPkg::srcFour;
                ctrl.immKind  = coreCtrlPkg::immJ;
                ctrl.regWrite = 1'b1;
                ctrl.pcSel    = coreCtrlPkg::pcJal;
            end
            rvIsaPkg::opJalr: if (f3 == rvIsaPkg::f3Jalr) begin
                ctrl.srcA     = coreCtrlPkg::srcPc;
                ctrl.srcB     = coreCtrlPkg::srcFour;
                ctrl.regWrite = 1'b1;
                ctrl.pcSel    = coreCtrlPkg::pcJalr;
            end
            default: ; // Unsupported, only the PC moves
        endcase
    end

endmodule

// ==== rtl/aluUnit.sv ====
module aluUnit (
    input  coreCtrlPkg::aluOp op,
    input  rvIsaPkg::word     a,
    input  rvIsaPkg::word     b,
    output rvIsaPkg::word     result,
    output logic              taken
);

    logic [4:0] shamt;
    logic       cmp;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            coreCtrlPkg::aluEq:   cmp = (a == b);
            coreCtrlPkg::aluNe:   cmp = (a != b);
            coreCtrlPkg::aluSlt,
            coreCtrlPkg::aluLt:   cmp = ($signed(a) < $signed(b));
            coreCtrlPkg::aluGe:   cmp = ($signed(a) >= $signed(b));
            coreCtrlPkg::aluSltu,
            coreCtrlPkg::aluLtu:  cmp = (a < b);
            coreCtrlPkg::aluGeu:  cmp = (a >= b);
            default:              cmp = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            coreCtrlPkg::aluAdd: result = a + b;
            coreCtrlPkg::aluSub: result = a - b;
            coreCtrlPkg::aluAnd: result = a & b;
            coreCtrlPkg::aluOr:  result = a | b;
            coreCtrlPkg::aluXor: result = a ^ b;
            coreCtrlPkg::aluSll: result = a << shamt;
            coreCtrlPkg::aluSrl: result = a >> shamt;
            coreCtrlPkg::aluSra: result = $signed(a) >>> shamt;
            default:             result = {31'd0, cmp}; // Compare ops give 0 or 1
        endcase
    end

    assign taken = cmp;

endmodule

// ==== rtl/regFile.sv ====
module regFile (
    input  logic            clk,
    input  logic            arstN,
    input  rvIsaPkg::regIdx rs1,
    input  rvIsaPkg::regIdx rs2,
    output rvIsaPkg::word   rs1Data,
    output rvIsaPkg::word   rs2Data,
    input  rvIsaPkg::regIdx rd,
    input  logic            wrEn,
    input  rvIsaPkg::word   wrData
);

    rvIsaPkg::word regs [1:31]; // No storage behind x0

    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && rd != '0) begin
            regs[rd] <= wrData;
        end
    end

endmodule

// ==== rtl/immGen.sv ====
module immGen (
    input  rvIsaPkg::instrWord  latchedInstr,
    input  coreCtrlPkg::immKind immKind,
    output rvIsaPkg::word       imm
);

    logic sign;

    assign sign = latchedInstr[31];

    always_comb begin
        case (immKind)
            coreCtrlPkg::immS: imm = {{20{sign}}, latchedInstr[31:25], latchedInstr[11:7]};
            coreCtrlPkg::immB: imm = {{19{sign}}, sign, latchedInstr[7],
                                      latchedInstr[30:25], latchedInstr[11:8], 1'b0};
            coreCtrlPkg::immJ: imm = {{11{sign}}, sign, latchedInstr[19:12],
                                      latchedInstr[20], latchedInstr[30:21], 1'b0};
            default:           imm = {{20{sign}}, latchedInstr[31:20]};
        endcase
    end

    // Shift amounts are the low five bits of immI, taken in the ALU

endmodule

// ==== rtl/coreCtrlPkg.sv ====
package coreCtrlPkg;

    typedef enum logic [1:0] {
        stFetch,
        stDecode,
        stExecute,
        stWriteback
    } stage;

    typedef enum logic [3:0] {
        aluAdd,  aluSub,  aluAnd,  aluOr,
        aluXor,  aluSlt,  aluSltu, aluSll,
        aluSrl,  aluSra,  aluEq,   aluNe,
        aluLt,   aluGe,   aluLtu,  aluGeu
    } aluOp;

    typedef enum logic [1:0] {immI, immS, immB, immJ} immKind;

    typedef enum logic {srcRs1, srcPc} srcA;

    typedef enum logic [1:0] {srcRs2, srcImm, srcFour} srcB;

    typedef enum logic [1:0] {pcPlus4, pcBranch, pcJal, pcJalr} pcSel;

    // Datapath controls, steady from decode through writeback
    typedef struct packed {
        srcA    srcA;
        srcB    srcB;
        aluOp   aluOp;
        immKind immKind;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   isBranch;
        pcSel   pcSel;
        logic   wbFromMem;
    } ctrlBundle;

endpackage

// ==== rtl/rvIsaPkg.sv ====
package rvIsaPkg;

    localparam int xlen    = 32;
    localparam int regIdxW = 5;

    typedef logic [xlen-1:0]    word;
    typedef logic [31:0]        instrWord;
    typedef logic [regIdxW-1:0] regIdx;
    typedef logic [6:0]         opcode;
    typedef logic [2:0]         funct3;
    typedef logic [6:0]         funct7;

    // Major opcodes
    localparam opcode opReg    = 7'b0110011;
    localparam opcode opImm    = 7'b0010011;
    localparam opcode opLoad   = 7'b0000011;
    localparam opcode opStore  = 7'b0100011;
    localparam opcode opBranch = 7'b1100011;
    localparam opcode opJal    = 7'b1101111;
    localparam opcode opJalr   = 7'b1100111;

    // Branch conditions
    localparam funct3 f3Beq  = 3'b000;
    localparam funct3 f3Bne  = 3'b001;
    localparam funct3 f3Blt  = 3'b100;
    localparam funct3 f3Bge  = 3'b101;
    localparam funct3 f3Bltu = 3'b110;
    localparam funct3 f3Bgeu = 3'b111;

    // ALU variants, shared by register and immediate forms
    localparam funct3 f3Add  = 3'b000;
    localparam funct3 f3Sll  = 3'b001;
    localparam funct3 f3Slt  = 3'b010;
    localparam funct3 f3Sltu = 3'b011;
    localparam funct3 f3Xor  = 3'b100;
    localparam funct3 f3Srl  = 3'b101; // Also SRA with f7Alt
    localparam funct3 f3Or   = 3'b110;
    localparam funct3 f3And  = 3'b111;

    localparam funct3 f3Word = 3'b010; // LW and SW
    localparam funct3 f3Jalr = 3'b000;

    localparam funct7 f7Alt = 7'b0100000; // SUB, SRA, SRAI

endpackage
